/* src.f */
+incdir+include
src/route_pkg.sv
src/table_rd_if.sv
src/neighbor_mem.sv
src/search_cfg.sv
src/best_neighbor.sv
src/route_top.sv
tb/route_properties.sv
tb/route_tb.sv

/* run.sh */
#!/bin/sh
# builds the route testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module route_tb -f src.f \
    --Mdir obj_dir -o route_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/route_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

/* tb/route_tb.sv */
`include "table_map.svh"

module route_tb;
    import route_pkg::*;

    localparam int LOAD_CYCLES = 6 * MAX_NEIGHBORS + 8;  // table bytes plus cfg writes
    localparam int MAX_CYCLES  = 20 * (7 * MAX_NEIGHBORS + 10) + 20 * LOAD_CYCLES;

    logic             clock;
    logic             nrst;
    logic             en;
    logic             start;
    word_t            mybest_q;
    word_t            mybest_h;
    logic             mem_we;
    logic [MEM_AW-1:0] mem_addr;
    logic [7:0]       mem_wdata;
    logic             cfg_we;
    logic [1:0]       cfg_addr;
    word_t            cfg_wdata;
    logic             done;
    logic             wr_en;
    logic             busy;
    word_t            besthop;
    word_t            bestneighbor_id;
    word_t            best_q;

    // testbench copy of the table and config
    word_t  tb_id   [MAX_NEIGHBORS];
    word_t  tb_hops [MAX_NEIGHBORS];
    word_t  tb_q    [MAX_NEIGHBORS];
    word_t  cur_node_id;
    word_t  cur_hop_limit;
    integer seed;

    // expected result of the running search
    word_t exp_hop;
    word_t exp_id;
    word_t exp_q;
    logic  exp_changed;
    int    exp_n;
    int    start_cycle;
    int    searches_started;
    int    results_seen;
    int    cycle;

    route_top #(
        .MEM_DEPTH (2048)
    ) u_dut (
        .clock           (clock),
        .nrst            (nrst),
        .en              (en),
        .start           (start),
        .mybest_q        (mybest_q),
        .mybest_h        (mybest_h),
        .mem_we          (mem_we),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .cfg_we          (cfg_we),
        .cfg_addr        (cfg_addr),
        .cfg_wdata       (cfg_wdata),
        .done            (done),
        .wr_en           (wr_en),
        .busy            (busy),
        .besthop         (besthop),
        .bestneighbor_id (bestneighbor_id),
        .best_q          (best_q)
    );

    always #2 clock = ~clock;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopped on the first mismatch");
        end
    endtask

    // replacement rule over the first n entries of the testbench table
    function automatic void ref_best(input word_t q_in, input word_t h_in, input word_t id_in,
                                     input int n, input word_t limit, output word_t hop_o,
                                     output word_t id_o, output word_t q_o,
                                     output logic changed_o);
        hop_o     = h_in;
        id_o      = id_in;
        q_o       = q_in;
        changed_o = 1'b0;
        for (int i = 0; i < n; i++) begin
            if (tb_hops[i] <= limit &&
                (tb_q[i] > q_o || (tb_q[i] == q_o && tb_hops[i] < hop_o))) begin
                hop_o     = tb_hops[i];
                id_o      = tb_id[i];
                q_o       = tb_q[i];
                changed_o = 1'b1;
            end
        end
    endfunction

    task automatic write_byte(input logic [MEM_AW-1:0] addr, input logic [7:0] data);
        mem_we    = 1'b1;
        mem_addr  = addr;
        mem_wdata = data;
        @(negedge clock);
        mem_we    = 1'b0;
    endtask

    task automatic write_cfg(input logic [1:0] addr, input word_t data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clock);
        cfg_we    = 1'b0;
    endtask

    task automatic load_table();
        for (int i = 0; i < MAX_NEIGHBORS; i++) begin
            write_byte(`NEIGHBOR_ID_BASE + 11'(2 * i), tb_id[i][7:0]);  // low byte first
            write_byte(`NEIGHBOR_ID_BASE + 11'(2 * i + 1), tb_id[i][15:8]);
            write_byte(`NEIGHBOR_HOPS_BASE + 11'(2 * i), tb_hops[i][7:0]);
            write_byte(`NEIGHBOR_HOPS_BASE + 11'(2 * i + 1), tb_hops[i][15:8]);
            write_byte(`NEIGHBOR_Q_BASE + 11'(2 * i), tb_q[i][7:0]);
            write_byte(`NEIGHBOR_Q_BASE + 11'(2 * i + 1), tb_q[i][15:8]);
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < MAX_NEIGHBORS; i++) begin
            tb_id[i]   = 16'($random(seed));
            tb_hops[i] = 16'($random(seed)) & 16'h000f;  // narrow ranges force ties
            tb_q[i]    = 16'($random(seed)) & 16'h001f;
        end
    endtask

    task automatic set_entry(input int i, input word_t id, input word_t hops, input word_t q);
        tb_id[i]   = id;
        tb_hops[i] = hops;
        tb_q[i]    = q;
    endtask

    // arm, pulse start and wait for the checker to see done
    task automatic run_search(input word_t q_in, input word_t h_in, input int n);
        ref_best(q_in, h_in, cur_node_id, n, cur_hop_limit, exp_hop, exp_id, exp_q,
                 exp_changed);
        exp_n    = n;
        en       = 1'b1;
        mybest_q = q_in;
        mybest_h = h_in;
        @(negedge clock);
        start = 1'b1;
        searches_started++;
        @(negedge clock);
        start       = 1'b0;
        start_cycle = cycle;  // counted from the edge that took start
        while (results_seen != searches_started) begin
            if (!done) begin
                check_value("busy during search", 32'(busy), 32'd1);  // high until done
            end
            @(negedge clock);
        end
    endtask

    // comparison process
    always @(negedge clock) begin
        if (nrst && done) begin
            check_value("done without a started search",
                        32'(searches_started - results_seen), 32'd1);
            check_value("done latency", 32'(cycle - start_cycle), 32'(7 * exp_n + 1));
            check_value("besthop", 32'(besthop), 32'(exp_hop));
            check_value("bestneighbor_id", 32'(bestneighbor_id), 32'(exp_id));
            check_value("best_q", 32'(best_q), 32'(exp_q));
            check_value("wr_en", 32'(wr_en), 32'(exp_changed));
            results_seen <= results_seen + 1;
        end
    end

    // watchdog
    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("CHECKS FAILED");
            $fatal(1, "timeout: run did not finish within %0d cycles", MAX_CYCLES);
        end
    end

    initial begin
        int n;
        seed             = 32'hbd354dc9;
        clock            = 1'b0;
        nrst             = 1'b0;
        en               = 1'b0;
        start            = 1'b0;
        mybest_q         = '0;
        mybest_h         = '0;
        mem_we           = 1'b0;
        mem_addr         = '0;
        mem_wdata        = '0;
        cfg_we           = 1'b0;
        cfg_addr         = '0;
        cfg_wdata        = '0;
        cycle            = 0;
        searches_started = 0;
        results_seen     = 0;
        cur_node_id      = '0;
        cur_hop_limit    = 16'hffff;
        repeat (3) @(negedge clock);
        nrst = 1'b1;

        // quiet outputs after reset
        check_value("done after reset", 32'(done), 32'd0);
        check_value("wr_en after reset", 32'(wr_en), 32'd0);
        check_value("busy after reset", 32'(busy), 32'd0);
        check_value("besthop after reset", 32'(besthop), 32'd0);
        check_value("bestneighbor_id after reset", 32'(bestneighbor_id), 32'd0);
        check_value("best_q after reset", 32'(best_q), 32'd0);

        // random tables and counts
        for (int t = 0; t < 12; t++) begin
            fill_random();
            load_table();
            n             = ($random(seed) & 31) + 1;
            cur_node_id   = 16'($random(seed));
            cur_hop_limit = 16'(($random(seed) & 15) + 2);
            write_cfg(CFG_NODE_ID, cur_node_id);
            write_cfg(CFG_COUNT, 16'(n));
            write_cfg(CFG_HOP_LIMIT, cur_hop_limit);
            run_search(16'($random(seed)) & 16'h001f, 16'($random(seed)) & 16'h000f, n);
        end

        // incoming pair beats the whole table
        write_cfg(CFG_COUNT, 16'd32);
        run_search(16'h0040, 16'd1, 32);
        check_value("kept q", 32'(exp_q), 32'h0040);
        check_value("kept hops", 32'(exp_hop), 32'd1);
        check_value("kept id", 32'(exp_id), 32'(cur_node_id));
        check_value("kept changed flag", 32'(exp_changed), 32'd0);

        // tie on q goes to fewer hops, entry 3 is over the limit
        for (int i = 0; i < MAX_NEIGHBORS; i++) begin
            set_entry(i, '0, '0, '0);
        end
        set_entry(0, 16'h0a00, 16'd5, 16'd50);
        set_entry(1, 16'h0a01, 16'd3, 16'd50);
        set_entry(2, 16'h0a02, 16'd3, 16'd50);  // equal hops, no replace
        set_entry(3, 16'h0a03, 16'd12, 16'd90);
        load_table();
        cur_hop_limit = 16'd10;
        write_cfg(CFG_COUNT, 16'd4);
        write_cfg(CFG_HOP_LIMIT, cur_hop_limit);
        run_search(16'd10, 16'd1, 4);
        check_value("tie winner id", 32'(exp_id), 32'h0a01);
        cur_hop_limit = 16'd12;
        write_cfg(CFG_HOP_LIMIT, cur_hop_limit);
        run_search(16'd10, 16'd1, 4);
        check_value("limit winner id", 32'(exp_id), 32'h0a03);

        // clamped counts
        fill_random();
        load_table();
        cur_hop_limit = 16'hffff;
        write_cfg(CFG_HOP_LIMIT, cur_hop_limit);
        write_cfg(CFG_COUNT, 16'd0);
        run_search(16'd0, 16'd15, 1);
        write_cfg(CFG_COUNT, 16'd40);
        run_search(16'd0, 16'd15, 32);

        // start while en is low must be ignored
        en = 1'b0;
        repeat (2) @(negedge clock);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        repeat (7 * MAX_NEIGHBORS + 10) @(negedge clock);
        check_value("results after start without en", 32'(results_seen),
                    32'(searches_started));

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* tb/route_properties.sv */
module route_properties (
    input logic clock,
    input logic nrst,
    input logic done,
    input logic wr_en,
    input logic busy
);

    // result strobes are single-cycle pulses
    assert property (@(posedge clock) disable iff (!nrst) done |=> !done)
        else $error("done stayed high for more than one cycle");

    assert property (@(posedge clock) disable iff (!nrst) wr_en |=> !wr_en)
        else $error("wr_en stayed high for more than one cycle");

    // table update only comes with a result
    assert property (@(posedge clock) disable iff (!nrst) wr_en |-> done)
        else $error("wr_en pulsed without done");

    assert property (@(posedge clock) disable iff (!nrst) done |-> !busy)
        else $error("busy still high while done is high");

    // quiet outputs after a reset edge
    assert property (@(posedge clock) !nrst |=> (!done && !wr_en && !busy))
        else $error("done, wr_en or busy high right after reset");

endmodule

bind route_top route_properties u_props (
    .clock (clock),
    .nrst  (nrst),
    .done  (done),
    .wr_en (wr_en),
    .busy  (busy)
);

/* src/route_top.sv */
module route_top #(
    parameter int MEM_DEPTH = 2048
) (
    input  logic                         clock,
    input  logic                         nrst,
    input  logic                         en,
    input  logic                         start,
    input  route_pkg::word_t             mybest_q,
    input  route_pkg::word_t             mybest_h,
    input  logic                         mem_we,
    input  logic [route_pkg::MEM_AW-1:0] mem_addr,
    input  logic [7:0]                   mem_wdata,
    input  logic                         cfg_we,
    input  logic [1:0]                   cfg_addr,
    input  route_pkg::word_t             cfg_wdata,
    output logic                         done,
    output logic                         wr_en,
    output logic                         busy,
    output route_pkg::word_t             besthop,
    output route_pkg::word_t             bestneighbor_id,
    output route_pkg::word_t             best_q
);
    import route_pkg::*;

    word_t            node_id;
    logic [CNT_W-1:0] neighbor_count;
    word_t            hop_limit;

    table_rd_if u_rd_if (.clock(clock));

    neighbor_mem #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_mem (
        .clock   (clock),
        .nrst    (nrst),
        .we      (mem_we),
        .waddr   (mem_addr),
        .wdata   (mem_wdata),
        .rd_port (u_rd_if.responder)
    );

    search_cfg u_cfg (
        .clock          (clock),
        .nrst           (nrst),
        .cfg_we         (cfg_we),
        .cfg_addr       (cfg_addr),
        .cfg_wdata      (cfg_wdata),
        .node_id        (node_id),
        .neighbor_count (neighbor_count),
        .hop_limit      (hop_limit)
    );

    best_neighbor u_search (
        .clock           (clock),
        .nrst            (nrst),
        .en              (en),
        .start           (start),
        .mybest_q        (mybest_q),
        .mybest_h        (mybest_h),
        .node_id         (node_id),
        .neighbor_count  (neighbor_count),
        .hop_limit       (hop_limit),
        .rd_port         (u_rd_if.requester),
        .done            (done),
        .wr_en           (wr_en),
        .busy            (busy),
        .besthop         (besthop),
        .bestneighbor_id (bestneighbor_id),
        .best_q          (best_q)
    );

endmodule

/* src/best_neighbor.sv */
`include "table_map.svh"

module best_neighbor (
    input  logic                         clock,
    input  logic                         nrst,
    input  logic                         en,
    input  logic                         start,
    input  route_pkg::word_t             mybest_q,
    input  route_pkg::word_t             mybest_h,
    input  route_pkg::word_t             node_id,
    input  logic [route_pkg::CNT_W-1:0]  neighbor_count,
    input  route_pkg::word_t             hop_limit,
    table_rd_if.requester                rd_port,
    output logic                         done,
    output logic                         wr_en,
    output logic                         busy,
    output route_pkg::word_t             besthop,
    output route_pkg::word_t             bestneighbor_id,
    output route_pkg::word_t             best_q
);
    import route_pkg::*;

    search_state_t     state;
    logic [IDX_W-1:0]  idx;          // current neighbour
    logic              rd_wait;      // read issued, word due next cycle
    logic              changed;      // some neighbour won
    logic              fetching;
    logic              last_nb;
    logic              better;
    logic [MEM_AW-1:0] list_base;

    // running best and the neighbour under test
    word_t run_q;
    word_t run_h;
    word_t run_id;
    word_t nb_id;
    word_t nb_hops;
    word_t nb_q;

    assign fetching = (state == s_fetch_id) || (state == s_fetch_hops) ||
                      (state == s_fetch_q);
    assign last_nb  = (CNT_W'(idx) == neighbor_count - CNT_W'(1));

    // replacement rule, hop limit first
    assign better = (nb_hops <= hop_limit) &&
                    ((nb_q > run_q) || ((nb_q == run_q) && (nb_hops < run_h)));

    always_comb begin
        case (state)
            s_fetch_hops: list_base = `NEIGHBOR_HOPS_BASE;
            s_fetch_q:    list_base = `NEIGHBOR_Q_BASE;
            default:      list_base = `NEIGHBOR_ID_BASE;
        endcase
    end

    assign rd_port.rd   = fetching && !rd_wait;
    assign rd_port.addr = list_base + MEM_AW'({idx, 1'b0});  // entry n at base + 2n

    always_ff @(posedge clock) begin
        if (!nrst) begin
            state           <= s_wait;
            idx             <= '0;
            rd_wait         <= 1'b0;
            changed         <= 1'b0;
            done            <= 1'b0;
            wr_en           <= 1'b0;
            busy            <= 1'b0;
            besthop         <= '0;
            bestneighbor_id <= '0;
            best_q          <= '0;
        end else begin
            done  <= 1'b0;  // pulses
            wr_en <= 1'b0;
            case (state)
                s_wait: begin
                    if (en) begin
                        state           <= s_armed;
                        besthop         <= '0;
                        bestneighbor_id <= '0;
                        best_q          <= '0;
                    end
                end
                s_armed: begin
                    if (!en) begin
                        state <= s_wait;
                    end else if (start) begin
                        state   <= s_fetch_id;
                        busy    <= 1'b1;
                        idx     <= '0;
                        rd_wait <= 1'b0;
                        changed <= 1'b0;
                    end
                end
                s_fetch_id: begin
                    if (rd_port.rvalid) begin
                        rd_wait <= 1'b0;
                        state   <= s_fetch_hops;
                    end else begin
                        rd_wait <= 1'b1;
                    end
                end
                s_fetch_hops: begin
                    if (rd_port.rvalid) begin
                        rd_wait <= 1'b0;
                        state   <= s_fetch_q;
                    end else begin
                        rd_wait <= 1'b1;
                    end
                end
                s_fetch_q: begin
                    if (rd_port.rvalid) begin
                        rd_wait <= 1'b0;
                        state   <= s_compare;
                    end else begin
                        rd_wait <= 1'b1;
                    end
                end
                s_compare: begin
                    if (better) begin
                        changed <= 1'b1;
                    end
                    if (last_nb) begin
                        state <= s_out;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= s_fetch_id;
                    end
                end
                s_out: begin
                    done            <= 1'b1;
                    wr_en           <= changed;
                    busy            <= 1'b0;
                    besthop         <= run_h;
                    bestneighbor_id <= run_id;
                    best_q          <= run_q;
                    state           <= s_wait;
                end
                default: begin
                    state <= s_wait;
                end
            endcase
        end
    end

    // running best, seeded at start
    always_ff @(posedge clock) begin
        if (state == s_armed && en && start) begin
            run_q  <= mybest_q;  // incoming pair is the first candidate
            run_h  <= mybest_h;
            run_id <= node_id;
        end else if (state == s_compare && better) begin
            run_q  <= nb_q;
            run_h  <= nb_hops;
            run_id <= nb_id;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_port.rvalid) begin
            case (state)
                s_fetch_id:   nb_id   <= rd_port.rdata;
                s_fetch_hops: nb_hops <= rd_port.rdata;
                s_fetch_q:    nb_q    <= rd_port.rdata;
                default: begin
                end
            endcase
        end
    end

endmodule

/* src/search_cfg.sv */
module search_cfg (
    input  logic                         clock,
    input  logic                         nrst,
    input  logic                         cfg_we,
    input  logic [1:0]                   cfg_addr,
    input  route_pkg::word_t             cfg_wdata,
    output route_pkg::word_t             node_id,
    output logic [route_pkg::CNT_W-1:0]  neighbor_count,
    output route_pkg::word_t             hop_limit
);
    import route_pkg::*;

    logic [CNT_W-1:0] count_clamped;

    // keep the count inside 1..MAX_NEIGHBORS
    always_comb begin
        if (cfg_wdata == '0) begin
            count_clamped = CNT_W'(1);
        end else if (cfg_wdata > word_t'(MAX_NEIGHBORS)) begin
            count_clamped = CNT_W'(MAX_NEIGHBORS);
        end else begin
            count_clamped = CNT_W'(cfg_wdata);
        end
    end

    always_ff @(posedge clock) begin
        if (!nrst) begin
            node_id        <= '0;
            neighbor_count <= CNT_W'(1);
            hop_limit      <= '1;  // no hop limit
        end else if (cfg_we) begin
            case (cfg_addr)
                CFG_NODE_ID: begin
                    node_id <= cfg_wdata;
                end
                CFG_COUNT: begin
                    neighbor_count <= count_clamped;
                end
                CFG_HOP_LIMIT: begin
                    hop_limit <= cfg_wdata;
                end
                default: begin
                    // address 3 is unmapped
                end
            endcase
        end
    end

endmodule

/* src/neighbor_mem.sv */
module neighbor_mem #(
    parameter int MEM_DEPTH = 2048
) (
    input  logic                        clock,
    input  logic                        nrst,
    input  logic                        we,
    input  logic [route_pkg::MEM_AW-1:0] waddr,
    input  logic [7:0]                  wdata,
    table_rd_if.responder               rd_port
);

    localparam int DEPTH_AW = $clog2(MEM_DEPTH);

    logic [7:0]          mem [MEM_DEPTH];
    logic [DEPTH_AW-1:0] wr_idx;
    logic [DEPTH_AW-1:0] lo_idx;
    logic [DEPTH_AW-1:0] hi_idx;

    assign wr_idx = DEPTH_AW'(waddr);
    assign lo_idx = DEPTH_AW'(rd_port.addr);
    assign hi_idx = lo_idx + 1'b1;  // wraps at MEM_DEPTH

    // host byte write
    always_ff @(posedge clock) begin
        if (we) begin
            mem[wr_idx] <= wdata;
        end
    end

    // word read, low byte first
    always_ff @(posedge clock) begin
        if (rd_port.rd) begin
            rd_port.rdata <= {mem[hi_idx], mem[lo_idx]};
        end
    end

    always_ff @(posedge clock) begin
        if (!nrst) begin
            rd_port.rvalid <= 1'b0;
        end else begin
            rd_port.rvalid <= rd_port.rd;  // fixed one-cycle latency
        end
    end

endmodule

/* src/table_rd_if.sv */
interface table_rd_if (
    input logic clock
);
    import route_pkg::*;

    logic              rd;      // one-cycle read strobe
    logic [MEM_AW-1:0] addr;    // byte address of low byte
    word_t             rdata;   // word, valid with rvalid
    logic              rvalid;  // one cycle after rd

    modport requester (
        input  clock,
        output rd,
        output addr,
        input  rdata,
        input  rvalid
    );

    modport responder (
        input  clock,
        input  rd,
        input  addr,
        output rdata,
        output rvalid
    );

endinterface

/* src/route_pkg.sv */
package route_pkg;

    localparam int WORD_W        = 16;  // table word width
    localparam int MEM_AW        = 11;  // byte address width
    localparam int MAX_NEIGHBORS = 32;  // table capacity

    localparam int IDX_W = $clog2(MAX_NEIGHBORS);      // neighbour index
    localparam int CNT_W = $clog2(MAX_NEIGHBORS + 1);  // count, 1..32

    // host register map
    localparam logic [1:0] CFG_NODE_ID   = 2'd0;
    localparam logic [1:0] CFG_COUNT     = 2'd1;
    localparam logic [1:0] CFG_HOP_LIMIT = 2'd2;

    typedef logic [WORD_W-1:0] word_t;  // ids, hops and q-values

    typedef enum logic [2:0] {
        s_wait,        // idle until en
        s_armed,       // en seen, waiting for start
        s_fetch_id,    // read neighbour id
        s_fetch_hops,  // read neighbour hop count
        s_fetch_q,     // read neighbour q-value
        s_compare,     // judge one neighbour
        s_out          // present result
    } search_state_t;

endpackage

/* include/table_map.svh */
`ifndef TABLE_MAP_SVH
`define TABLE_MAP_SVH

// byte base of each 16-bit little-endian list, entry n at base + 2n
`define NEIGHBOR_ID_BASE    11'h072
`define NEIGHBOR_HOPS_BASE  11'h132
`define NEIGHBOR_Q_BASE     11'h172

`endif
